// ==== Makefile ====
TOP = rv_exec_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --assert --top-module $(TOP) -f filelist.f -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
rtl/rv_isa_pkg.sv
rtl/rv_exec_pkg.sv
rtl/rv_decode.sv
rtl/rv_alu.sv
rtl/rv_writeback.sv
rtl/rv_exec_top.sv
test/rv_exec_properties.sv
test/rv_exec_tb.sv

// ==== rtl/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic                  stall_i,
   input  rv_exec_pkg::dec_pkt_t dec_i,
   input  rv_exec_pkg::wb_fwd_t  fwd_i,
   output rv_exec_pkg::ex_pkt_t  ex_o
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic [XLEN-1:0]     a, b_reg, b;
   logic                eq, lt, ltu;
   logic                is_branch, taken;
   logic                sign_a, sign_b;
   logic [2*XLEN+1:0]   mul_a, mul_b, mul_full;
   logic                div_zero, div_ovf;
   logic [XLEN-1:0]     div_b, quot_s, rem_s, quot_u, rem_u;
   logic [XLEN-1:0]     link, rel_target, jalr_target;
   ex_pkt_t             ex_d;
   ex_pkt_t             ex_q;

   // Result stage holds the newer value of a matching register.
   assign a = (fwd_i.we && fwd_i.rd != '0 && fwd_i.rd == dec_i.rs1) ? fwd_i.data : dec_i.op1;
   assign b_reg = (fwd_i.we && fwd_i.rd != '0 && fwd_i.rd == dec_i.rs2) ? fwd_i.data : dec_i.op2;
   assign b = dec_i.use_imm ? dec_i.imm : b_reg;

   assign eq  = (a == b);
   assign lt  = ($signed(a) < $signed(b));
   assign ltu = (a < b);

   // Both operands widened to 66 bits, so one multiplier covers all four forms.
   assign sign_a   = (dec_i.op == OP_MULH) || (dec_i.op == OP_MULHSU);
   assign sign_b   = (dec_i.op == OP_MULH);
   assign mul_a    = {{(XLEN+2){sign_a & a[XLEN-1]}}, a};
   assign mul_b    = {{(XLEN+2){sign_b & b[XLEN-1]}}, b};
   assign mul_full = mul_a * mul_b;

   assign div_zero = (b == '0);
   assign div_ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
   assign div_b    = div_zero ? {{(XLEN-1){1'b0}}, 1'b1} : b; // Keeps the dividers defined.
   assign quot_s   = $signed(a) / $signed(div_b);
   assign rem_s    = $signed(a) % $signed(div_b);
   assign quot_u   = a / div_b;
   assign rem_u    = a % div_b;

   assign link        = dec_i.pc + 32'd4;
   assign rel_target  = dec_i.pc + dec_i.imm;
   assign jalr_target = (a + dec_i.imm) & ~{{(XLEN-1){1'b0}}, 1'b1};

   assign is_branch = (dec_i.op == OP_BEQ) || (dec_i.op == OP_BNE) ||
                      (dec_i.op == OP_BLT) || (dec_i.op == OP_BGE) ||
                      (dec_i.op == OP_BLTU) || (dec_i.op == OP_BGEU);

   always_comb begin
      case (dec_i.op)
         OP_BEQ:  taken = eq;
         OP_BNE:  taken = !eq;
         OP_BLT:  taken = lt;
         OP_BGE:  taken = !lt;
         OP_BLTU: taken = ltu;
         OP_BGEU: taken = !ltu;
         default: taken = 1'b0;
      endcase
   end

   always_comb begin
      ex_d          = '0;
      ex_d.valid    = dec_i.valid;
      ex_d.illegal  = dec_i.illegal;
      ex_d.rd       = dec_i.rd;
      ex_d.we       = dec_i.valid && !dec_i.illegal && !is_branch && (dec_i.rd != '0);
      ex_d.redirect = dec_i.valid && !dec_i.illegal &&
                      ((dec_i.op == OP_JAL) || (dec_i.op == OP_JALR) || taken);
      case (dec_i.op)
         OP_ADD:    ex_d.result = a + b;
         OP_SUB:    ex_d.result = a - b;
         OP_XOR:    ex_d.result = a ^ b;
         OP_OR:     ex_d.result = a | b;
         OP_AND:    ex_d.result = a & b;
         OP_SLL:    ex_d.result = a << b[SHAMT_W-1:0];
         OP_SRL:    ex_d.result = a >> b[SHAMT_W-1:0];
         OP_SRA:    ex_d.result = $signed(a) >>> b[SHAMT_W-1:0];
         OP_SLT:    ex_d.result = {{(XLEN-1){1'b0}}, lt};
         OP_SLTU:   ex_d.result = {{(XLEN-1){1'b0}}, ltu};
         OP_LUI:    ex_d.result = dec_i.imm;
         OP_AUIPC:  ex_d.result = rel_target;
         OP_JAL,
         OP_JALR:   ex_d.result = link;
         OP_MUL:    ex_d.result = mul_full[XLEN-1:0];
         OP_MULH,
         OP_MULHSU,
         OP_MULHU:  ex_d.result = mul_full[2*XLEN-1:XLEN];
         OP_DIV:    ex_d.result = div_zero ? '1 : (div_ovf ? a : quot_s);
         OP_DIVU:   ex_d.result = div_zero ? '1 : quot_u;
         OP_REM:    ex_d.result = div_zero ? a : (div_ovf ? '0 : rem_s);
         OP_REMU:   ex_d.result = div_zero ? a : rem_u;
         default:   ex_d.result = '0; // Branches write nothing.
      endcase
      if (dec_i.op == OP_JALR) ex_d.target = jalr_target;
      else if ((dec_i.op == OP_JAL) || is_branch) ex_d.target = rel_target;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ex_q.valid    <= 1'b0;
         ex_q.illegal  <= 1'b0;
         ex_q.we       <= 1'b0;
         ex_q.redirect <= 1'b0;
      end else if (!stall_i) begin
         ex_q <= ex_d;
      end
   end

   assign ex_o = ex_q;

endmodule

// ==== rtl/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          stall_i,
   input  logic                          instr_valid_i,
   input  logic [rv_isa_pkg::XLEN-1:0]   instr_i,
   input  logic [rv_isa_pkg::XLEN-1:0]   pc_i,
   output logic [rv_isa_pkg::REG_AW-1:0] rs1_addr_o,
   output logic [rv_isa_pkg::REG_AW-1:0] rs2_addr_o,
   input  logic [rv_isa_pkg::XLEN-1:0]   rs1_data_i,
   input  logic [rv_isa_pkg::XLEN-1:0]   rs2_data_i,
   output rv_exec_pkg::dec_pkt_t         dec_o
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic [XLEN-1:0] imm_i, imm_u, imm_j, imm_b;
   dec_pkt_t        dec_d;
   dec_pkt_t        dec_q;

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
   assign imm_u = {instr_i[31:12], 12'b0};
   assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
   assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

   always_comb begin
      dec_d         = '0;
      dec_d.valid   = instr_valid_i;
      dec_d.illegal = 1'b0;
      dec_d.op      = OP_ADD;
      dec_d.rs1     = rs1_addr_o;
      dec_d.rs2     = rs2_addr_o;
      dec_d.rd      = instr_i[11:7];
      dec_d.op1     = rs1_data_i;
      dec_d.op2     = rs2_data_i;
      dec_d.pc      = pc_i;
      case (opcode)
         OPC_OP: begin
            if (funct7 == F7_MULDIV) begin
               case (funct3)
                  F3_MUL:    dec_d.op = OP_MUL;
                  F3_MULH:   dec_d.op = OP_MULH;
                  F3_MULHSU: dec_d.op = OP_MULHSU;
                  F3_MULHU:  dec_d.op = OP_MULHU;
                  F3_DIV:    dec_d.op = OP_DIV;
                  F3_DIVU:   dec_d.op = OP_DIVU;
                  F3_REM:    dec_d.op = OP_REM;
                  default:   dec_d.op = OP_REMU;
               endcase
            end else if (funct7 == F7_ALT) begin
               if (funct3 == F3_ADD_SUB) dec_d.op = OP_SUB;
               else if (funct3 == F3_SRL_SRA) dec_d.op = OP_SRA;
               else dec_d.illegal = 1'b1;
            end else if (funct7 == F7_BASE) begin
               case (funct3)
                  F3_ADD_SUB: dec_d.op = OP_ADD;
                  F3_SLL:     dec_d.op = OP_SLL;
                  F3_SLT:     dec_d.op = OP_SLT;
                  F3_SLTU:    dec_d.op = OP_SLTU;
                  F3_XOR:     dec_d.op = OP_XOR;
                  F3_SRL_SRA: dec_d.op = OP_SRL;
                  F3_OR:      dec_d.op = OP_OR;
                  default:    dec_d.op = OP_AND;
               endcase
            end else begin
               dec_d.illegal = 1'b1;
            end
         end
         OPC_OP_IMM: begin
            dec_d.imm     = imm_i;
            dec_d.use_imm = 1'b1;
            case (funct3)
               F3_ADD_SUB: dec_d.op = OP_ADD;
               F3_SLT:     dec_d.op = OP_SLT;
               F3_SLTU:    dec_d.op = OP_SLTU;
               F3_XOR:     dec_d.op = OP_XOR;
               F3_OR:      dec_d.op = OP_OR;
               F3_AND:     dec_d.op = OP_AND;
               F3_SLL: begin
                  dec_d.op      = OP_SLL;
                  dec_d.illegal = (funct7 != F7_BASE);
               end
               default: begin // Srli or srai.
                  dec_d.op      = (funct7 == F7_ALT) ? OP_SRA : OP_SRL;
                  dec_d.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
               end
            endcase
         end
         OPC_LUI: begin
            dec_d.op  = OP_LUI;
            dec_d.imm = imm_u;
         end
         OPC_AUIPC: begin
            dec_d.op  = OP_AUIPC;
            dec_d.imm = imm_u;
         end
         OPC_JAL: begin
            dec_d.op  = OP_JAL;
            dec_d.imm = imm_j;
         end
         OPC_JALR: begin
            dec_d.op      = OP_JALR;
            dec_d.imm     = imm_i;
            dec_d.illegal = (funct3 != F3_JALR);
         end
         OPC_BRANCH: begin
            dec_d.imm = imm_b;
            case (funct3)
               F3_BEQ:  dec_d.op = OP_BEQ;
               F3_BNE:  dec_d.op = OP_BNE;
               F3_BLT:  dec_d.op = OP_BLT;
               F3_BGE:  dec_d.op = OP_BGE;
               F3_BLTU: dec_d.op = OP_BLTU;
               F3_BGEU: dec_d.op = OP_BGEU;
               default: dec_d.illegal = 1'b1;
            endcase
         end
         default: dec_d.illegal = 1'b1; // Loads, stores, fences, system.
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         dec_q.valid   <= 1'b0;
         dec_q.illegal <= 1'b0;
      end else if (!stall_i) begin
         dec_q <= dec_d;
      end
   end

   assign dec_o = dec_q;

endmodule

// ==== rtl/rv_exec_pkg.sv ====
package rv_exec_pkg;

   typedef enum logic [5:0] {
      OP_ADD,
      OP_SUB,
      OP_XOR,
      OP_OR,
      OP_AND,
      OP_SLL,
      OP_SRL,
      OP_SRA,
      OP_SLT,
      OP_SLTU,
      OP_LUI,
      OP_AUIPC,
      OP_JAL,
      OP_JALR,
      OP_BEQ,
      OP_BNE,
      OP_BLT,
      OP_BGE,
      OP_BLTU,
      OP_BGEU,
      OP_MUL,
      OP_MULH,
      OP_MULHSU,
      OP_MULHU,
      OP_DIV,
      OP_DIVU,
      OP_REM,
      OP_REMU
   } alu_op_e;

   typedef struct packed {
      logic                              valid;
      logic                              illegal;
      alu_op_e                           op;
      logic [rv_isa_pkg::REG_AW-1:0]     rs1;
      logic [rv_isa_pkg::REG_AW-1:0]     rs2;
      logic [rv_isa_pkg::REG_AW-1:0]     rd;
      logic [rv_isa_pkg::XLEN-1:0]       op1;
      logic [rv_isa_pkg::XLEN-1:0]       op2;
      logic [rv_isa_pkg::XLEN-1:0]       imm;
      logic [rv_isa_pkg::XLEN-1:0]       pc;
      logic                              use_imm; // Operand 2 comes from imm.
   } dec_pkt_t;

   typedef struct packed {
      logic                              valid;
      logic                              illegal;
      logic [rv_isa_pkg::REG_AW-1:0]     rd;
      logic                              we;       // Already qualified, rd nonzero.
      logic [rv_isa_pkg::XLEN-1:0]       result;
      logic                              redirect;
      logic [rv_isa_pkg::XLEN-1:0]       target;
   } ex_pkt_t;

   typedef struct packed {
      logic                              we;
      logic [rv_isa_pkg::REG_AW-1:0]     rd;
      logic [rv_isa_pkg::XLEN-1:0]       data;
   } wb_fwd_t;

endpackage

// ==== rtl/rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          stall_i,
   input  logic                          instr_valid_i,
   input  logic [rv_isa_pkg::XLEN-1:0]   instr_i,
   input  logic [rv_isa_pkg::XLEN-1:0]   pc_i,
   output logic                          wb_valid_o,
   output logic [rv_isa_pkg::REG_AW-1:0] wb_rd_o,
   output logic [rv_isa_pkg::XLEN-1:0]   wb_data_o,
   output logic                          redirect_valid_o,
   output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc_o,
   output logic                          illegal_o
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic [REG_AW-1:0] rs1_addr, rs2_addr;
   logic [XLEN-1:0]   rs1_data, rs2_data;
   dec_pkt_t          dec;
   ex_pkt_t           ex;
   wb_fwd_t           fwd;

   rv_decode u_decode (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .stall_i       (stall_i),
      .instr_valid_i (instr_valid_i),
      .instr_i       (instr_i),
      .pc_i          (pc_i),
      .rs1_addr_o    (rs1_addr),
      .rs2_addr_o    (rs2_addr),
      .rs1_data_i    (rs1_data),
      .rs2_data_i    (rs2_data),
      .dec_o         (dec)
   );

   rv_alu u_alu (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .dec_i   (dec),
      .fwd_i   (fwd),
      .ex_o    (ex)
   );

   rv_writeback u_writeback (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .stall_i          (stall_i),
      .ex_i             (ex),
      .rs1_addr_i       (rs1_addr),
      .rs2_addr_i       (rs2_addr),
      .rs1_data_o       (rs1_data),
      .rs2_data_o       (rs2_data),
      .fwd_o            (fwd),
      .wb_valid_o       (wb_valid_o),
      .wb_rd_o          (wb_rd_o),
      .wb_data_o        (wb_data_o),
      .redirect_valid_o (redirect_valid_o),
      .redirect_pc_o    (redirect_pc_o),
      .illegal_o        (illegal_o)
   );

endmodule

// ==== rtl/rv_isa_pkg.sv ====
package rv_isa_pkg;

   localparam int XLEN     = 32;
   localparam int NUM_REGS = 32;
   localparam int REG_AW   = $clog2(NUM_REGS);
   localparam int SHAMT_W  = $clog2(XLEN);

   // Major opcodes, bits 6:0 of the instruction.
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SRL_SRA = 3'b101;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_JALR    = 3'b000;

   localparam logic [2:0] F3_BEQ     = 3'b000;
   localparam logic [2:0] F3_BNE     = 3'b001;
   localparam logic [2:0] F3_BLT     = 3'b100;
   localparam logic [2:0] F3_BGE     = 3'b101;
   localparam logic [2:0] F3_BLTU    = 3'b110;
   localparam logic [2:0] F3_BGEU    = 3'b111;

   localparam logic [2:0] F3_MUL     = 3'b000;
   localparam logic [2:0] F3_MULH    = 3'b001;
   localparam logic [2:0] F3_MULHSU  = 3'b010;
   localparam logic [2:0] F3_MULHU   = 3'b011;
   localparam logic [2:0] F3_DIV     = 3'b100;
   localparam logic [2:0] F3_DIVU    = 3'b101;
   localparam logic [2:0] F3_REM     = 3'b110;
   localparam logic [2:0] F3_REMU    = 3'b111;

   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_ALT     = 7'b0100000; // Sub and sra.
   localparam logic [6:0] F7_MULDIV  = 7'b0000001;

endpackage

// ==== rtl/rv_writeback.sv ====
`timescale 1ns/1ps

module rv_writeback (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          stall_i,
   input  rv_exec_pkg::ex_pkt_t          ex_i,
   input  logic [rv_isa_pkg::REG_AW-1:0] rs1_addr_i,
   input  logic [rv_isa_pkg::REG_AW-1:0] rs2_addr_i,
   output logic [rv_isa_pkg::XLEN-1:0]   rs1_data_o,
   output logic [rv_isa_pkg::XLEN-1:0]   rs2_data_o,
   output rv_exec_pkg::wb_fwd_t          fwd_o,
   output logic                          wb_valid_o,
   output logic [rv_isa_pkg::REG_AW-1:0] wb_rd_o,
   output logic [rv_isa_pkg::XLEN-1:0]   wb_data_o,
   output logic                          redirect_valid_o,
   output logic [rv_isa_pkg::XLEN-1:0]   redirect_pc_o,
   output logic                          illegal_o
);
   import rv_isa_pkg::*;
   import rv_exec_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS]; // Entry 0 is never written.
   wb_fwd_t         fwd;

   assign fwd.we   = ex_i.valid && ex_i.we;
   assign fwd.rd   = ex_i.rd;
   assign fwd.data = ex_i.result;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (!stall_i && fwd.we) begin
         regs[fwd.rd] <= fwd.data;
      end
   end

   // Write-through read ports.
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                       (fwd.we && fwd.rd == rs1_addr_i) ? fwd.data : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                       (fwd.we && fwd.rd == rs2_addr_i) ? fwd.data : regs[rs2_addr_i];

   assign fwd_o = fwd;

   assign wb_valid_o       = fwd.we;
   assign wb_rd_o          = ex_i.rd;
   assign wb_data_o        = ex_i.result;
   assign redirect_valid_o = ex_i.valid && ex_i.redirect;
   assign redirect_pc_o    = ex_i.target;
   assign illegal_o        = ex_i.valid && ex_i.illegal;

endmodule

// ==== test/rv_exec_properties.sv ====
`timescale 1ns/1ps

module rv_exec_properties (
   input logic                          clk_i,
   input logic                          rst_i,
   input logic                          stall_i,
   input logic                          wb_valid_o,
   input logic [rv_isa_pkg::REG_AW-1:0] wb_rd_o,
   input logic [rv_isa_pkg::XLEN-1:0]   wb_data_o,
   input logic                          redirect_valid_o,
   input logic [rv_isa_pkg::XLEN-1:0]   redirect_pc_o,
   input logic                          illegal_o
);

   valid_low_after_reset: assert property (@(posedge clk_i)
      !rst_i |=> (!wb_valid_o && !redirect_valid_o && !illegal_o))
      else $error("valid outputs high after reset");

   wb_and_illegal_exclusive: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(wb_valid_o && illegal_o))
      else $error("write-back and illegal high together");

   wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_i)
      wb_valid_o |-> (wb_rd_o != '0))
      else $error("write-back to register zero");

   // A stalled edge leaves every stage register as it was.
   stable_on_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
      stall_i |=> ($stable(wb_valid_o) && $stable(wb_rd_o) && $stable(wb_data_o) &&
                   $stable(redirect_valid_o) && $stable(redirect_pc_o) &&
                   $stable(illegal_o)))
      else $error("outputs changed across a stalled cycle");

endmodule

bind rv_exec_top rv_exec_properties u_props (.*);

// ==== test/rv_exec_tb.sv ====
`timescale 1ns/1ps

module rv_exec_tb;
   import rv_isa_pkg::*;

   localparam int MAX_TESTS    = 64;
   localparam int RESET_CYCLES = 8;
   localparam int CYCLE_MARGIN = 40;

   typedef struct packed {
      logic [8*16-1:0]   name;
      logic [XLEN-1:0]   instr;
      logic [XLEN-1:0]   pc;
      logic              stall;
      logic              wb_valid;
      logic [REG_AW-1:0] rd;
      logic [XLEN-1:0]   data;
      logic              redirect;
      logic [XLEN-1:0]   target;
      logic              illegal;
   } test_vec_t;

   logic              clk_i;
   logic              rst_i;
   logic              stall_i;
   logic              instr_valid_i;
   logic [XLEN-1:0]   instr_i;
   logic [XLEN-1:0]   pc_i;
   logic              wb_valid_o;
   logic [REG_AW-1:0] wb_rd_o;
   logic [XLEN-1:0]   wb_data_o;
   logic              redirect_valid_o;
   logic [XLEN-1:0]   redirect_pc_o;
   logic              illegal_o;

   test_vec_t vecs [MAX_TESTS];
   int        num_tests;
   int        pass_count;
   int        fail_count;
   int        cycle_count;
   int        cycle_limit;
   int        last_checked;
   int        pending[$]; // Lines sampled but not yet at the outputs.
   bit        loaded;

   rv_exec_top uut (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .stall_i          (stall_i),
      .instr_valid_i    (instr_valid_i),
      .instr_i          (instr_i),
      .pc_i             (pc_i),
      .wb_valid_o       (wb_valid_o),
      .wb_rd_o          (wb_rd_o),
      .wb_data_o        (wb_data_o),
      .redirect_valid_o (redirect_valid_o),
      .redirect_pc_o    (redirect_pc_o),
      .illegal_o        (illegal_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   task automatic load_tests(output bit ok);
      int                fd;
      int                n;
      logic [8*128-1:0]  line;
      logic [8*16-1:0]   nm;
      logic [31:0]       ins, pc, st, wbv, rd, dat, rv, tgt, ill;
      ok = 1'b0;
      fd = $fopen("test/rv_exec_tests.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
               n = $sscanf(line, "%s %h %h %d %d %d %h %d %h %d",
                           nm, ins, pc, st, wbv, rd, dat, rv, tgt, ill);
               if (n == 10) begin // Comment and blank lines fall out here.
                  vecs[num_tests] = '{nm, ins, pc, st[0], wbv[0], rd[REG_AW-1:0],
                                      dat, rv[0], tgt, ill[0]};
                  num_tests++;
               end
            end
         end
         $fclose(fd);
         ok = (num_tests > 0);
      end
   endtask

   // Compares the outputs with line exp_idx and reports under line tag_idx.
   task automatic check_outputs(input int exp_idx, input int tag_idx);
      test_vec_t e;
      int        errs;
      e    = vecs[exp_idx];
      errs = 0;
      assert (wb_valid_o === e.wb_valid) else begin
         $display("mismatch wb_valid_o: got %h expected %h", wb_valid_o, e.wb_valid);
         errs++;
      end
      if (e.wb_valid) begin
         assert (wb_rd_o === e.rd) else begin
            $display("mismatch wb_rd_o: got %h expected %h", wb_rd_o, e.rd);
            errs++;
         end
         assert (wb_data_o === e.data) else begin
            $display("mismatch wb_data_o: got %h expected %h", wb_data_o, e.data);
            errs++;
         end
      end
      assert (redirect_valid_o === e.redirect) else begin
         $display("mismatch redirect_valid_o: got %h expected %h", redirect_valid_o,
                  e.redirect);
         errs++;
      end
      if (e.redirect) begin
         assert (redirect_pc_o === e.target) else begin
            $display("mismatch redirect_pc_o: got %h expected %h", redirect_pc_o, e.target);
            errs++;
         end
      end
      assert (illegal_o === e.illegal) else begin
         $display("mismatch illegal_o: got %h expected %h", illegal_o, e.illegal);
         errs++;
      end
      if (errs == 0) begin
         pass_count++;
         $display("test %0s: pass", vecs[tag_idx].name);
      end else begin
         fail_count++;
         $display("test %0s: fail with %0d errors", vecs[tag_idx].name, errs);
      end
   endtask

   task automatic check_reset();
      logic low;
      low = !wb_valid_o && !redirect_valid_o && !illegal_o;
      assert (low) else begin
         $display("valid outputs were not low after reset");
      end
      if (low) begin
         pass_count++;
         $display("test reset: pass");
      end else begin
         fail_count++;
         $display("test reset: fail");
      end
   endtask

   // Drives each line and checks it once it reaches the outputs.
   task automatic run_tests();
      cycle_limit = num_tests + RESET_CYCLES + CYCLE_MARGIN;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_i = 1'b1;
      check_reset();
      for (int i = 0; i < num_tests; i++) begin
         stall_i       = vecs[i].stall;
         instr_valid_i = 1'b1;
         instr_i       = vecs[i].instr;
         pc_i          = vecs[i].pc;
         @(posedge clk_i);
         #2;
         if (vecs[i].stall) begin
            if (last_checked >= 0) check_outputs(last_checked, i); // Outputs must hold.
         end else begin
            pending.push_back(i);
            if (pending.size() > 1) begin
               last_checked = pending.pop_front();
               check_outputs(last_checked, last_checked);
            end
         end
      end
      stall_i       = 1'b0;
      instr_valid_i = 1'b0;
      @(posedge clk_i);
      #2;
      if (pending.size() > 0) begin
         last_checked = pending.pop_front();
         check_outputs(last_checked, last_checked);
      end
      $display("summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   initial begin
      rst_i         = 1'b0;
      stall_i       = 1'b0;
      instr_valid_i = 1'b0;
      instr_i       = '0;
      pc_i          = '0;
      num_tests     = 0;
      pass_count    = 0;
      fail_count    = 0;
      cycle_count   = 0;
      cycle_limit   = 0;
      last_checked  = -1;
      load_tests(loaded);
      if (!loaded) begin
         $display("could not read any test lines from the test data file");
         $display("SOME TESTS FAILED");
         $finish;
      end else begin
         run_tests();
      end
   end

endmodule

// ==== test/rv_exec_tests.txt ====
# name instr pc stall | expected: wb_valid rd(dec) data redirect target illegal
# Stall lines expect the outputs of the previous check to hold.
readzero   015A02B3 00000100 0 1 5  00000000 0 00000000 0
lui        800000B7 00000104 0 1 1  80000000 0 00000000 0
addi_neg   FFF00113 00000108 0 1 2  FFFFFFFF 0 00000000 0
auipc      12345197 0000010C 0 1 3  1234510C 0 00000000 0
addi_7     00700213 00000110 0 1 4  00000007 0 00000000 0
addi_m8    FF800293 00000114 0 1 5  FFFFFFF8 0 00000000 0
add_fwd    00520333 00000118 0 1 6  FFFFFFFF 0 00000000 0
sub        405203B3 0000011C 0 1 7  0000000F 0 00000000 0
sra        4042D433 00000120 0 1 8  FFFFFFFF 0 00000000 0
srl        0042D4B3 00000124 0 1 9  01FFFFFF 0 00000000 0
sll        00421533 00000128 0 1 10 00000380 0 00000000 0
slt        0042A5B3 0000012C 0 1 11 00000001 0 00000000 0
sltu       0042B633 00000130 0 1 12 00000000 0 00000000 0
srai       4022D693 00000134 0 1 13 FFFFFFFE 0 00000000 0
write_x0   00520013 00000138 0 0 0  00000000 0 00000000 0
xor        00414733 0000013C 0 1 14 FFFFFFF8 0 00000000 0
mul        024287B3 00000140 0 1 15 FFFFFFC8 0 00000000 0
mulh       02429833 00000144 0 1 16 FFFFFFFF 0 00000000 0
mulhsu     0222A8B3 00000148 0 1 17 FFFFFFF8 0 00000000 0
mulhu      02213933 0000014C 0 1 18 FFFFFFFE 0 00000000 0
div        0242C9B3 00000150 0 1 19 FFFFFFFF 0 00000000 0
rem        0242EA33 00000154 0 1 20 FFFFFFFF 0 00000000 0
div_zero   02024AB3 00000158 0 1 21 FFFFFFFF 0 00000000 0
rem_zero   02026B33 0000015C 0 1 22 00000007 0 00000000 0
div_ovf    0220CBB3 00000160 0 1 23 80000000 0 00000000 0
rem_ovf    0220EC33 00000164 0 1 24 00000000 0 00000000 0
divu       0242DCB3 00000168 0 1 25 24924923 0 00000000 0
remu       0242FD33 0000016C 0 1 26 00000003 0 00000000 0
divu_zero  02025DB3 00000170 0 1 27 FFFFFFFF 0 00000000 0
set_x6     06400313 00000174 0 1 6  00000064 0 00000000 0
gap_nop    00000013 00000178 0 0 0  00000000 0 00000000 0
fwd_gap    00630333 0000017C 0 1 6  000000C8 0 00000000 0
fwd_b2b    00630333 00000180 0 1 6  00000190 0 00000000 0
fwd_addi   00130313 00000184 0 1 6  00000191 0 00000000 0
jal        010000EF 00000188 0 1 1  0000018C 1 00000198 0
jalr       004303E7 0000018C 0 1 7  00000190 1 00000194 0
beq_taken  00420463 00000190 0 0 0  00000000 1 00000198 0
bne_not    00421463 00000194 0 0 0  00000000 0 00000000 0
blt_back   FE42C8E3 00000198 0 0 0  00000000 1 00000188 0
bltu_not   0042E463 0000019C 0 0 0  00000000 0 00000000 0
bgeu_taken 0042F463 000001A0 0 0 0  00000000 1 000001A8 0
stall_a    00100493 000001A4 1 0 0  00000000 0 00000000 0
stall_b    00100493 000001A8 1 0 0  00000000 0 00000000 0
addi_x9    00900493 000001AC 0 1 9  00000009 0 00000000 0
add_x10    00948533 000001B0 0 1 10 00000012 0 00000000 0
load_ill   00012083 000001B4 0 0 0  00000000 0 00000000 1
store_ill  0020A023 000001B8 0 0 0  00000000 0 00000000 1
unknown    FFFFFFFF 000001BC 0 0 0  00000000 0 00000000 1
x1_kept    00008593 000001C0 0 1 11 0000018C 0 00000000 0
